// File: common/video_pkg.sv
// video stream types and frame geometry, imported by every block that touches pixels
`default_nettype none

package video_pkg;

    // one greyscale sample
    typedef logic [7:0] pixel_t;

    // frame size, fixed at build time
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HEIGHT = 5;

    // position within the frame
    typedef logic [2:0] col_t;
    typedef logic [2:0] row_t;

    // three pixels side by side or stacked, oldest or uppermost in the high byte
    typedef logic [23:0] pixel_triple_t;

endpackage

`default_nettype wire

// File: common/filter_pkg.sv
// kernel coefficients and arithmetic widths of the blur pipeline, imported by the filter
`default_nettype none

package filter_pkg;

    typedef logic [2:0] weight_t;

    // 1-2-1 / 2-4-2 / 1-2-1, top-left first
    localparam weight_t KERNEL_WEIGHTS [9] = '{
        3'd1, 3'd2, 3'd1,
        3'd2, 3'd4, 3'd2,
        3'd1, 3'd2, 3'd1
    };

    // 255 * 4 fits in 10 bits, 255 * 16 in 12
    typedef logic [9:0]  product_t;
    typedef logic [11:0] sum_t;

    // weights add up to 16
    localparam int NORM_SHIFT     = 4;
    localparam int FILTER_LATENCY = 4;

endpackage

`default_nettype wire

// File: common/window_if.sv
// valid/ready links between line buffer, window assembler and filter
`default_nettype none

// one column of three vertically adjacent pixels with the position of the newest
interface column_if
    import video_pkg::*;
();
    pixel_triple_t column;
    col_t          col_idx;
    row_t          row_idx;
    logic          valid;
    logic          ready;

    modport source (output column, col_idx, row_idx, valid, input ready);
    modport sink   (input column, col_idx, row_idx, valid, output ready);
endinterface

// complete 3x3 window, leftmost pixel of each row in the high byte
interface window_if
    import video_pkg::*;
();
    pixel_triple_t top_row;
    pixel_triple_t mid_row;
    pixel_triple_t bot_row;
    logic          valid;
    logic          ready;

    modport source (output top_row, mid_row, bot_row, valid, input ready);
    modport sink   (input top_row, mid_row, bot_row, valid, output ready);
endinterface

`default_nettype wire

// File: line_buffer/line_buffer.sv
// turns the raster pixel stream into registered three-pixel columns using two row memories
`default_nettype none

module line_buffer
    import video_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  pixel_t   pixel_in,
    input  logic     pixel_valid_in,
    input  logic     frame_start_in,
    output logic     pixel_ready_out,
    column_if.source col_out
);

    // pixels of the previous row and the one before, indexed by column
    pixel_t row1_mem [IMG_WIDTH];
    pixel_t row2_mem [IMG_WIDTH];

    col_t col_cnt;
    row_t row_cnt;
    col_t cur_col;
    row_t cur_row;
    logic accept;
    logic col_valid;

    // free output register or a taker downstream
    assign pixel_ready_out = !col_valid || col_out.ready;
    assign accept          = pixel_valid_in && pixel_ready_out;

    // frame start forces this pixel to the origin
    assign cur_col = frame_start_in ? '0 : col_cnt;
    assign cur_row = frame_start_in ? '0 : row_cnt;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            col_valid <= 1'b0;
        end else begin
            if (accept) begin
                col_valid <= 1'b1;
                if (cur_col == col_t'(IMG_WIDTH - 1)) begin
                    col_cnt <= '0;
                    if (cur_row == row_t'(IMG_HEIGHT - 1)) begin
                        row_cnt <= '0;
                    end else begin
                        row_cnt <= cur_row + row_t'(1);
                    end
                end else begin
                    col_cnt <= cur_col + col_t'(1);
                    row_cnt <= cur_row;
                end
            end else if (col_out.ready) begin
                col_valid <= 1'b0;
            end
        end
    end

    // read both rows, push the older one up and store the new pixel
    always_ff @(posedge clk_in) begin
        if (accept) begin
            row2_mem[cur_col] <= row1_mem[cur_col];
            row1_mem[cur_col] <= pixel_in;
            col_out.column    <= {row2_mem[cur_col], row1_mem[cur_col], pixel_in};
            col_out.col_idx   <= cur_col;
            col_out.row_idx   <= cur_row;
        end
    end

    assign col_out.valid = col_valid;

endmodule

`default_nettype wire

// File: line_buffer/window_assembler.sv
// shifts incoming columns into a 3x3 window and passes on only the interior windows
`default_nettype none

module window_assembler
    import video_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    column_if.sink   col_in,
    window_if.source win_out
);

    // left to right, the rightmost column is the newest
    pixel_triple_t col_left;
    pixel_triple_t col_mid;
    pixel_triple_t col_right;
    logic          win_valid;
    logic          accept;
    logic          interior;

    // the shift register doubles as the window register, so it moves only when free
    assign col_in.ready = !win_valid || win_out.ready;
    assign accept       = col_in.valid && col_in.ready;

    // needs two rows above and two columns to the left
    assign interior = (col_in.col_idx >= col_t'(2)) && (col_in.row_idx >= row_t'(2));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            win_valid <= 1'b0;
        end else if (accept) begin
            win_valid <= interior;
        end else if (win_out.ready) begin
            win_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            col_left  <= col_mid;
            col_mid   <= col_right;
            col_right <= col_in.column;
        end
    end

    // regroup columns into rows, top pixel sits in the high byte of each column
    assign win_out.top_row = {col_left[23:16], col_mid[23:16], col_right[23:16]};
    assign win_out.mid_row = {col_left[15:8], col_mid[15:8], col_right[15:8]};
    assign win_out.bot_row = {col_left[7:0], col_mid[7:0], col_right[7:0]};
    assign win_out.valid   = win_valid;

endmodule

`default_nettype wire

// File: logic/gaussian_filter.sv
// four-stage 3x3 gaussian kernel pipeline with a single stall shared by all stages
`default_nettype none

module gaussian_filter
    import video_pkg::*;
    import filter_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    window_if.sink win_in,
    output pixel_t blurred_out,
    output logic   blurred_valid_out,
    input  logic   blurred_ready_in,
    output logic   busy_out
);

    logic [FILTER_LATENCY-1:0] stage_valid;
    logic                      advance;
    logic [71:0]               win_flat;
    product_t                  s1_prod [9];
    product_t                  s2_prod [9];
    sum_t                      sum_comb;
    sum_t                      s3_sum;

    // everything moves together unless the output is full and not taken
    assign advance     = !stage_valid[FILTER_LATENCY-1] || blurred_ready_in;
    assign win_in.ready = advance;

    // top-left pixel ends up in the high byte
    assign win_flat = {win_in.top_row, win_in.mid_row, win_in.bot_row};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[FILTER_LATENCY-2:0], win_in.valid};
        end
    end

    // stage 1 weights, stage 2 just re-registers the products
    always_ff @(posedge clk_in) begin
        if (advance) begin
            for (int k = 0; k < 9; k++) begin
                s1_prod[k] <= product_t'(win_flat[(8 - k) * 8 +: 8])
                              * product_t'(KERNEL_WEIGHTS[k]);
                s2_prod[k] <= s1_prod[k];
            end
        end
    end

    always_comb begin
        sum_comb = '0;
        for (int k = 0; k < 9; k++) begin
            sum_comb = sum_comb + sum_t'(s2_prod[k]);
        end
    end

    // stage 3 sums, stage 4 divides by 16 with truncation
    always_ff @(posedge clk_in) begin
        if (advance) begin
            s3_sum      <= sum_comb;
            blurred_out <= pixel_t'(s3_sum >> NORM_SHIFT);
        end
    end

    assign blurred_valid_out = stage_valid[FILTER_LATENCY-1];
    assign busy_out          = |stage_valid;

endmodule

`default_nettype wire

// File: logic/blur_top.sv
// top level of the streaming 3x3 gaussian blur, plain valid/ready ports on both sides
`default_nettype none

module blur_top
    import video_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  pixel_t pixel_in,
    input  logic   pixel_valid_in,
    input  logic   frame_start_in,
    output logic   pixel_ready_out,
    output pixel_t blurred_out,
    output logic   blurred_valid_out,
    input  logic   blurred_ready_in,
    output logic   busy_out
);

    column_if col_link ();
    window_if win_link ();

    line_buffer u_line_buffer (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .pixel_in        (pixel_in),
        .pixel_valid_in  (pixel_valid_in),
        .frame_start_in  (frame_start_in),
        .pixel_ready_out (pixel_ready_out),
        .col_out         (col_link.source)
    );

    window_assembler u_window_assembler (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .col_in  (col_link.sink),
        .win_out (win_link.source)
    );

    gaussian_filter u_gaussian_filter (
        .clk_in            (clk_in),
        .rst_in            (rst_in),
        .win_in            (win_link.sink),
        .blurred_out       (blurred_out),
        .blurred_valid_out (blurred_valid_out),
        .blurred_ready_in  (blurred_ready_in),
        .busy_out          (busy_out)
    );

endmodule

`default_nettype wire

// File: test/blur_tb.sv
// self-checking testbench for blur_top, replays the frame stored in test/blur_testdata.txt
`default_nettype none

module blur_tb
    import video_pkg::*;
();

    localparam int NUM_PIXELS      = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_EXPECTED    = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);
    localparam int NUM_FRAMES      = 3;
    localparam int NUM_STRAY       = 3;
    localparam int TOTAL_OUTPUTS   = NUM_FRAMES * NUM_EXPECTED;
    localparam int RESET_CYCLES    = 10;
    localparam int SEED            = 66206;
    localparam int WATCHDOG_CYCLES = (NUM_FRAMES * NUM_PIXELS + NUM_STRAY) * 20 + 200;

    logic   clk_in            = 1'b0;
    logic   rst_in            = 1'b1;
    pixel_t pixel_in          = '0;
    logic   pixel_valid_in    = 1'b0;
    logic   frame_start_in    = 1'b0;
    logic   pixel_ready_out;
    pixel_t blurred_out;
    logic   blurred_valid_out;
    logic   blurred_ready_in  = 1'b1;
    logic   busy_out;

    // input pixels first, expected outputs after them
    pixel_t data_mem [NUM_PIXELS + NUM_EXPECTED];
    pixel_t received [$];
    int     out_count    = 0;
    logic   random_ready = 1'b0;
    logic   held_pending = 1'b0;
    pixel_t held_value   = '0;

    blur_top DUT (
        .clk_in            (clk_in),
        .rst_in            (rst_in),
        .pixel_in          (pixel_in),
        .pixel_valid_in    (pixel_valid_in),
        .frame_start_in    (frame_start_in),
        .pixel_ready_out   (pixel_ready_out),
        .blurred_out       (blurred_out),
        .blurred_valid_out (blurred_valid_out),
        .blurred_ready_in  (blurred_ready_in),
        .busy_out          (busy_out)
    );

    always #50 clk_in = ~clk_in;

    task automatic check_pixel(input pixel_t got, input pixel_t expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ready is looked at on the falling edge, where it cannot change
    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_in);
            taken = pixel_ready_out;
            @(posedge clk_in);
        end
    endtask

    task automatic send_frame(input int count, input logic with_gaps);
        int idle;
        for (int i = 0; i < count; i++) begin
            pixel_in       <= data_mem[i];
            pixel_valid_in <= 1'b1;
            frame_start_in <= (i == 0);
            wait_accept();
            idle = with_gaps ? $urandom_range(3) : 0;
            if (idle > 0) begin
                pixel_valid_in <= 1'b0;
                frame_start_in <= 1'b0;
                repeat (idle) @(posedge clk_in);
            end
        end
        pixel_valid_in <= 1'b0;
        frame_start_in <= 1'b0;
    endtask

    task automatic wait_outputs(input int count);
        while (out_count < count) @(posedge clk_in);
    endtask

    // roughly two cycles in three ready once back-pressure is on
    always @(posedge clk_in) begin
        if (random_ready) begin
            blurred_ready_in <= ($urandom_range(2) != 0);
        end else begin
            blurred_ready_in <= 1'b1;
        end
    end

    // a transfer seen here completes on the next rising edge
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (held_pending) begin
                check_flag(blurred_valid_out, 1'b1, "blurred_valid_out while stalled");
                check_pixel(blurred_out, held_value, "blurred_out while stalled");
            end
            held_pending = 1'b0;
            if (blurred_valid_out) begin
                check_flag(busy_out, 1'b1, "busy_out with a valid output");
                if (blurred_ready_in) begin
                    check_pixel(blurred_out, data_mem[NUM_PIXELS + out_count % NUM_EXPECTED],
                                $sformatf("blurred pixel %0d", out_count));
                    received.push_back(blurred_out);
                    out_count++;
                end else begin
                    held_pending = 1'b1;
                    held_value   = blurred_out;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("blurred outputs did not arrive in time, %0d of %0d received",
                 out_count, TOTAL_OUTPUTS);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(SEED));
        $readmemh("test/blur_testdata.txt", data_mem);
        if ($isunknown(data_mem[NUM_PIXELS + NUM_EXPECTED - 1])) begin
            $display("the test data file could not be read completely");
            $display("Testbench failed");
            $fatal(1, "missing test data");
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        check_flag(blurred_valid_out, 1'b0, "blurred_valid_out after reset");
        check_flag(busy_out, 1'b0, "busy_out after reset");
        check_flag(pixel_ready_out, 1'b1, "pixel_ready_out after reset");
        @(posedge clk_in);

        // first frame without gaps and with the output always ready
        send_frame(NUM_PIXELS, 1'b0);
        wait_outputs(NUM_EXPECTED);
        @(negedge clk_in);
        check_flag(busy_out, 1'b0, "busy_out after the first frame");
        @(posedge clk_in);

        // aborted frame leaves the counters mid-row, only frame start realigns them
        send_frame(NUM_STRAY, 1'b0);

        // two frames back to back with idle cycles and back-pressure
        random_ready <= 1'b1;
        send_frame(NUM_PIXELS, 1'b1);
        send_frame(NUM_PIXELS, 1'b1);
        random_ready <= 1'b0;
        wait_outputs(TOTAL_OUTPUTS);
        @(negedge clk_in);
        check_flag(busy_out, 1'b0, "busy_out after the last frame");
        repeat (20) @(posedge clk_in);

        if (received.size() == TOTAL_OUTPUTS) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d blurred pixels received, %0d expected", received.size(), TOTAL_OUTPUTS);
            $display("Testbench failed");
            $fatal(1, "wrong number of outputs");
        end
    end

endmodule

`default_nettype wire

// File: test/blur_testdata.txt
// 8x5 input frame, one hex pixel per line in raster order (40 lines)
// then the 18 expected blurred pixels of the interior windows in raster order
0A
14
1E
28
32
3C
46
50
FF
00
80
40
C8
64
32
19
05
FA
21
4D
B4
5A
FF
FF
11
63
90
03
42
F0
0C
C9
78
79
7A
7B
7C
7D
7E
7F
56
48
59
73
6D
63
71
5D
57
7C
8B
96
6C
67
50
6E
8B
8F

// File: project.f
common/video_pkg.sv
common/filter_pkg.sv
common/window_if.sv
line_buffer/line_buffer.sv
line_buffer/window_assembler.sv
logic/gaussian_filter.sv
logic/blur_top.sv
test/blur_tb.sv

// File: Bender.yml
package:
  name: gaussian_blur

sources:
  - common/video_pkg.sv
  - common/filter_pkg.sv
  - common/window_if.sv
  - line_buffer/line_buffer.sv
  - line_buffer/window_assembler.sv
  - logic/gaussian_filter.sv
  - logic/blur_top.sv
  - target: test
    files:
      - test/blur_tb.sv
